// ==== verilog/scc_regs_pkg.sv ====
// The address map fixes every width here and the design has no read-back path
package scc_regs_pkg;

	// ----------------------------------------------------------------------
	// Bus and register widths
	// ----------------------------------------------------------------------

	typedef logic [15:0] addr_t;
	typedef logic [7:0]  data_t;
	typedef logic [7:0]  bank_t;
	typedef logic [11:0] freq_t;
	typedef logic [3:0]  vol_t;

	// Tone channels A to E
	localparam int NUM_CH = 5;

	// ----------------------------------------------------------------------
	// Encodings
	// ----------------------------------------------------------------------

	// SRAM channel id of a wave-memory access
	typedef enum logic [2:0] {
		CH_A = 3'd0,
		CH_B = 3'd1,
		CH_C = 3'd2,
		CH_D = 3'd3,
		CH_E = 3'd4
	} chan_t;

	// Register page hit by the current address
	typedef enum logic [1:0] {
		WIN_NONE = 2'd0,
		WIN_SCC  = 2'd1,
		WIN_SCCI = 2'd2
	} win_t;

	// Region from address bits 14:13 (4000h region is bank 0)
	typedef enum logic [1:0] {
		REG_BANK2 = 2'b00,
		REG_BANK3 = 2'b01,
		REG_BANK0 = 2'b10,
		REG_BANK1 = 2'b11
	} region_t;

	// Bank 2 value that opens the SCC page at 9800h
	localparam bank_t SCC_BANK_KEY = 8'h3F;

	// Tone register block offsets inside each page
	localparam logic [7:0] TONE_BASE_SCC  = 8'h80;
	localparam logic [7:0] TONE_BASE_SCCI = 8'hA0;

endpackage

// ==== verilog/bank_mapper.sv ====
// Bank writes decode on address bit 12 alone so any write with it set in an unlocked region lands
`timescale 1ns/1ns

module bank_mapper
	import scc_regs_pkg::*;
(
	input  logic  clk,
	input  logic  nreset,
	input  logic  wrreq,
	input  addr_t address,
	input  data_t wrdata,
	output bank_t ext_memory_address,
	output win_t  window
);

	region_t    region;
	logic [1:0] bank_sel;
	bank_t      bank [4];
	logic       scci_enable;
	logic [3:0] ram_mode;
	logic       mode_wr;
	logic       bank_wr;
	logic       page_hit;

	// ----------------------------------------------------------------------
	// Region decode
	// ----------------------------------------------------------------------

	assign region = region_t'(address[14:13]);

	always_comb begin
		case (region)
			REG_BANK0: bank_sel = 2'd0;
			REG_BANK1: bank_sel = 2'd1;
			REG_BANK2: bank_sel = 2'd2;
			default:   bank_sel = 2'd3;
		endcase
	end

	// ----------------------------------------------------------------------
	// Mode register at BFFE-BFFF
	// ----------------------------------------------------------------------

	assign mode_wr = wrreq && (region == REG_BANK3) && (&address[12:1]);

	always_ff @(posedge clk) begin
		if (!nreset) begin
			scci_enable <= 1'b0;
			ram_mode    <= 4'b0000;
		end else if (mode_wr) begin
			scci_enable <= wrdata[5];
			// Bit 4 locks every bank, bits 2:0 lock banks 2 to 0 one by one
			ram_mode    <= {wrdata[4], wrdata[2:0] | {3{wrdata[4]}}};
		end
	end

	// ----------------------------------------------------------------------
	// Bank registers
	// ----------------------------------------------------------------------

	assign bank_wr = wrreq && address[12] && !ram_mode[bank_sel];

	always_ff @(posedge clk) begin
		if (!nreset) begin
			bank[0] <= 8'd0;
			bank[1] <= 8'd1;
			bank[2] <= 8'd2;
			bank[3] <= 8'd3;
		end else if (bank_wr) begin
			bank[bank_sel] <= wrdata;
		end
	end

	// Upper memory address follows the region being accessed
	assign ext_memory_address = bank[bank_sel];

	// ----------------------------------------------------------------------
	// Page window decode
	// ----------------------------------------------------------------------

	// x800-x8FF inside the region
	assign page_hit = (address[12:8] == 5'b11000);

	always_comb begin
		if (page_hit && (region == REG_BANK2) && (bank[2] == SCC_BANK_KEY)
				&& !scci_enable) begin
			window = WIN_SCC;
		end else if (page_hit && (region == REG_BANK3) && bank[3][7]
				&& scci_enable) begin
			window = WIN_SCCI;
		end else begin
			window = WIN_NONE;
		end
	end

endmodule

// ==== verilog/wave_access_decode.sv ====
// Strobes last one cycle and sram_id and sram_a are only meaningful while a strobe is high
`timescale 1ns/1ns

module wave_access_decode
	import scc_regs_pkg::*;
(
	input  logic       clk,
	input  logic       nreset,
	input  logic       wrreq,
	input  logic       rdreq,
	input  win_t       window,
	input  addr_t      address,
	output chan_t      sram_id,
	output logic [6:0] sram_a,
	output logic       sram_oe,
	output logic       sram_we
);

	logic [7:0] offset;
	logic       hit_rw;
	logic       hit_ro;
	logic       hit;
	chan_t      chan;

	assign offset = address[7:0];

	// ----------------------------------------------------------------------
	// Range decode inside the page
	// ----------------------------------------------------------------------

	always_comb begin
		hit_rw = 1'b0;
		hit_ro = 1'b0;
		chan   = chan_t'({1'b0, offset[6:5]});
		case (window)
			WIN_SCC: begin
				if (!offset[7]) begin
					// 00-7F is waves A to D
					hit_rw = 1'b1;
				end else if (offset[7:5] == 3'b101) begin
					// A0-BF mirrors channel E for reads only
					hit_ro = 1'b1;
					chan   = CH_E;
				end
			end
			WIN_SCCI: begin
				// 00-9F is waves A to E
				if (!offset[7] || (offset[7:5] == 3'b100)) begin
					hit_rw = 1'b1;
					chan   = chan_t'(offset[7:5]);
				end
			end
			default: begin
				hit_rw = 1'b0;
			end
		endcase
	end

	assign hit = hit_rw || hit_ro;

	// ----------------------------------------------------------------------
	// Registered SRAM access
	// ----------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (!nreset) begin
			sram_oe <= 1'b0;
			sram_we <= 1'b0;
		end else begin
			sram_oe <= hit && rdreq;
			sram_we <= hit_rw && wrreq;
		end
	end

	// Id and address hold the last access
	always_ff @(posedge clk) begin
		if (hit && (rdreq || wrreq)) begin
			sram_id <= chan;
			sram_a  <= {2'b00, offset[4:0]};
		end
	end

endmodule

// ==== verilog/tone_regs.sv ====
// Tone registers are write only and take effect one clock after the write
`timescale 1ns/1ns

module tone_regs
	import scc_regs_pkg::*;
(
	input  logic               clk,
	input  logic               nreset,
	input  logic               wrreq,
	input  win_t               window,
	input  addr_t              address,
	input  data_t              wrdata,
	output freq_t [NUM_CH-1:0] frequency_count,
	output vol_t  [NUM_CH-1:0] volume,
	output logic  [NUM_CH-1:0] tone_enable
);

	logic [7:0]        base;
	logic [7:0]        rel;
	logic              tone_hit;
	logic [3:0]        reg_sel;
	logic [NUM_CH-1:0] freq_lo_we;
	logic [NUM_CH-1:0] freq_hi_we;
	logic [NUM_CH-1:0] vol_we;
	logic              en_we;

	// ----------------------------------------------------------------------
	// Register select
	// ----------------------------------------------------------------------

	// Both pages use the same layout at different offsets
	assign base     = (window == WIN_SCCI) ? TONE_BASE_SCCI : TONE_BASE_SCC;
	assign rel      = address[7:0] - base;
	assign tone_hit = wrreq && (window != WIN_NONE) && (rel[7:4] == 4'h0);
	assign reg_sel  = rel[3:0];

	always_comb begin
		for (int i = 0; i < NUM_CH; i++) begin
			// 0-9 hold low/high frequency pairs
			freq_lo_we[i] = tone_hit && (reg_sel == 4'(2 * i));
			freq_hi_we[i] = tone_hit && (reg_sel == 4'(2 * i + 1));
			// A-E hold the volumes
			vol_we[i]     = tone_hit && (reg_sel == 4'(10 + i));
		end
	end

	// F is the channel enable mask
	assign en_we = tone_hit && (reg_sel == 4'hF);

	// ----------------------------------------------------------------------
	// Tone registers
	// ----------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (!nreset) begin
			frequency_count <= '0;
			volume          <= '0;
			tone_enable     <= '0;
		end else begin
			for (int i = 0; i < NUM_CH; i++) begin
				if (freq_lo_we[i]) begin
					frequency_count[i][7:0] <= wrdata;
				end
				if (freq_hi_we[i]) begin
					frequency_count[i][11:8] <= wrdata[3:0];
				end
				if (vol_we[i]) begin
					volume[i] <= wrdata[3:0];
				end
			end
			if (en_we) begin
				tone_enable <= wrdata[NUM_CH-1:0];
			end
		end
	end

endmodule

// ==== verilog/scc_regs_top.sv ====
// Requests are single-cycle strobes with no back-pressure and every request is taken in its cycle
`timescale 1ns/1ns

module scc_regs_top
	import scc_regs_pkg::*;
(
	input  logic                 clk,
	input  logic                 nreset,
	input  logic                 wrreq,
	input  logic                 rdreq,
	input  addr_t                address,
	input  data_t                wrdata,

	// External ROM/RAM bank
	output bank_t                ext_memory_address,

	// Wave memory
	output chan_t                sram_id,
	output logic [6:0]           sram_a,
	output logic                 sram_oe,
	output logic                 sram_we,

	// Tone generator controls
	output freq_t [NUM_CH-1:0]   frequency_count,
	output vol_t  [NUM_CH-1:0]   volume,
	output logic  [NUM_CH-1:0]   tone_enable
);

	// Page currently addressed, decoded from bank and mode state
	win_t window;

	// ----------------------------------------------------------------------
	// Bank and mode registers
	// ----------------------------------------------------------------------

	bank_mapper u_bank_mapper (
		.clk                (clk),
		.nreset             (nreset),
		.wrreq              (wrreq),
		.address            (address),
		.wrdata             (wrdata),
		.ext_memory_address (ext_memory_address),
		.window             (window)
	);

	// ----------------------------------------------------------------------
	// Wave-memory access and tone registers
	// ----------------------------------------------------------------------

	wave_access_decode u_wave_access_decode (
		.clk     (clk),
		.nreset  (nreset),
		.wrreq   (wrreq),
		.rdreq   (rdreq),
		.window  (window),
		.address (address),
		.sram_id (sram_id),
		.sram_a  (sram_a),
		.sram_oe (sram_oe),
		.sram_we (sram_we)
	);

	tone_regs u_tone_regs (
		.clk             (clk),
		.nreset          (nreset),
		.wrreq           (wrreq),
		.window          (window),
		.address         (address),
		.wrdata          (wrdata),
		.frequency_count (frequency_count),
		.volume          (volume),
		.tone_enable     (tone_enable)
	);

endmodule

// ==== verif/scc_regs_assert.sv ====
// Shadow model starts from the reset state and sram_id and sram_a are compared only under a strobe
`timescale 1ns/1ns

module scc_regs_assert
	import scc_regs_pkg::*;
(
	input logic               clk,
	input logic               nreset,
	input logic               wrreq,
	input logic               rdreq,
	input addr_t              address,
	input data_t              wrdata,
	input bank_t              ext_memory_address,
	input chan_t              sram_id,
	input logic [6:0]         sram_a,
	input logic               sram_oe,
	input logic               sram_we,
	input freq_t [NUM_CH-1:0] frequency_count,
	input vol_t  [NUM_CH-1:0] volume,
	input logic  [NUM_CH-1:0] tone_enable
);

	int error_count = 0;

	bank_t              sh_bank [4];
	logic               sh_scci;
	logic [3:0]         sh_lock;
	logic [1:0]         idx;
	logic [7:0]         off;
	logic               in_scc;
	logic               in_scci;
	logic               wave_rd;
	logic               wave_wr;
	logic [2:0]         wave_ch;
	logic [7:0]         tone_rel;
	logic               tone_wr;
	bank_t              exp_ext;
	logic               exp_oe;
	logic               exp_we;
	logic [2:0]         exp_id;
	logic [6:0]         exp_a;
	freq_t [NUM_CH-1:0] exp_freq;
	vol_t  [NUM_CH-1:0] exp_vol;
	logic  [NUM_CH-1:0] exp_en;

	// ----------------------------------------------------------------------
	// Expected decode from the shadow state
	// ----------------------------------------------------------------------

	// Region 10 is bank 0, 11 bank 1, 00 bank 2, 01 bank 3
	always_comb begin
		case (address[14:13])
			2'b10:   idx = 2'd0;
			2'b11:   idx = 2'd1;
			2'b00:   idx = 2'd2;
			default: idx = 2'd3;
		endcase
	end

	assign off     = address[7:0];
	assign exp_ext = sh_bank[idx];
	assign in_scc  = (idx == 2'd2) && (address[12:8] == 5'h18)
		&& (sh_bank[2] == SCC_BANK_KEY) && !sh_scci;
	assign in_scci = (idx == 2'd3) && (address[12:8] == 5'h18) && sh_bank[3][7] && sh_scci;

	always_comb begin
		wave_rd = 1'b0;
		wave_wr = 1'b0;
		wave_ch = {1'b0, off[6:5]};
		if (in_scc && (off < 8'h80)) begin
			wave_rd = 1'b1;
			wave_wr = 1'b1;
		end else if (in_scc && (off >= 8'hA0) && (off <= 8'hBF)) begin
			// Channel E is read only in the SCC page
			wave_rd = 1'b1;
			wave_ch = 3'd4;
		end else if (in_scci && (off < 8'hA0)) begin
			wave_rd = 1'b1;
			wave_wr = 1'b1;
			wave_ch = off[7:5];
		end
		tone_rel = off - (in_scci ? TONE_BASE_SCCI : TONE_BASE_SCC);
		tone_wr  = wrreq && (in_scc || in_scci) && (tone_rel < 8'h10);
	end

	// ----------------------------------------------------------------------
	// Shadow registers and expected outputs
	// ----------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (!nreset) begin
			sh_bank[0] <= 8'd0;
			sh_bank[1] <= 8'd1;
			sh_bank[2] <= 8'd2;
			sh_bank[3] <= 8'd3;
			sh_scci    <= 1'b0;
			sh_lock    <= 4'h0;
			exp_oe     <= 1'b0;
			exp_we     <= 1'b0;
			exp_freq   <= '0;
			exp_vol    <= '0;
			exp_en     <= '0;
		end else begin
			if (wrreq && address[12] && !sh_lock[idx]) begin
				sh_bank[idx] <= wrdata;
			end
			if (wrreq && (idx == 2'd3) && (&address[12:1])) begin
				sh_scci <= wrdata[5];
				sh_lock <= wrdata[4] ? 4'hF : {1'b0, wrdata[2:0]};
			end
			exp_oe <= rdreq && wave_rd;
			exp_we <= wrreq && wave_wr;
			if ((rdreq && wave_rd) || (wrreq && wave_wr)) begin
				exp_id <= wave_ch;
				exp_a  <= {2'b00, off[4:0]};
			end
			if (tone_wr && (tone_rel < 8'd10) && tone_rel[0]) begin
				exp_freq[tone_rel[3:1]][11:8] <= wrdata[3:0];
			end else if (tone_wr && (tone_rel < 8'd10)) begin
				exp_freq[tone_rel[3:1]][7:0] <= wrdata;
			end else if (tone_wr && (tone_rel < 8'd15)) begin
				exp_vol[tone_rel[3:0] - 4'd10] <= wrdata[3:0];
			end else if (tone_wr) begin
				exp_en <= wrdata[4:0];
			end
		end
	end

	// ----------------------------------------------------------------------
	// Checks
	// ----------------------------------------------------------------------

	a_bank_map: assert property (@(posedge clk) disable iff (!nreset)
			ext_memory_address == exp_ext)
		else begin
			$error("CHECK FAILED bank_map expected %0h actual %0h",
				$sampled(exp_ext), $sampled(ext_memory_address));
			error_count++;
		end

	a_strobes: assert property (@(posedge clk) disable iff (!nreset)
			{sram_oe, sram_we} == {exp_oe, exp_we})
		else begin
			$error("CHECK FAILED sram_strobes expected %0b actual %0b",
				$sampled({exp_oe, exp_we}), $sampled({sram_oe, sram_we}));
			error_count++;
		end

	a_sram_addr: assert property (@(posedge clk) disable iff (!nreset)
			(sram_oe || sram_we) |-> ({sram_id, sram_a} == {exp_id, exp_a}))
		else begin
			$error("CHECK FAILED sram_id_addr expected %0h actual %0h",
				$sampled({exp_id, exp_a}), $sampled({sram_id, sram_a}));
			error_count++;
		end

	a_freq: assert property (@(posedge clk) disable iff (!nreset)
			frequency_count == exp_freq)
		else begin
			$error("CHECK FAILED frequency expected %0h actual %0h",
				$sampled(exp_freq), $sampled(frequency_count));
			error_count++;
		end

	a_vol: assert property (@(posedge clk) disable iff (!nreset) volume == exp_vol)
		else begin
			$error("CHECK FAILED volume expected %0h actual %0h",
				$sampled(exp_vol), $sampled(volume));
			error_count++;
		end

	a_enable: assert property (@(posedge clk) disable iff (!nreset) tone_enable == exp_en)
		else begin
			$error("CHECK FAILED tone_enable expected %0b actual %0b",
				$sampled(exp_en), $sampled(tone_enable));
			error_count++;
		end

endmodule

bind scc_regs_top scc_regs_assert u_assert (.*);

// ==== verif/scc_regs_tb.sv ====
// Checking lives in the bound checker, which must be compiled with this bench
`timescale 1ns/1ns

module scc_regs_tb
	import scc_regs_pkg::*;
();

	logic               clk = 1'b0;
	logic               nreset;
	logic               wrreq;
	logic               rdreq;
	addr_t              address;
	data_t              wrdata;
	bank_t              ext_memory_address;
	chan_t              sram_id;
	logic [6:0]         sram_a;
	logic               sram_oe;
	logic               sram_we;
	freq_t [NUM_CH-1:0] frequency_count;
	vol_t  [NUM_CH-1:0] volume;
	logic  [NUM_CH-1:0] tone_enable;
	int                 seed = 32'h6ae4_8291;

	scc_regs_top u_dut (.*);

	always #4 clk = ~clk;

	// Stop at the first failed assertion
	always @(negedge clk) begin
		if (u_dut.u_assert.error_count != 0) begin
			$display("Test FAILED");
			$fatal(1, "Stopped at the first failed assertion");
		end
	end

	// ----------------------------------------------------------------------
	// Bus tasks
	// ----------------------------------------------------------------------

	function automatic data_t rand_byte();
		return data_t'($random(seed));
	endfunction

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic write_reg(input addr_t addr, input data_t data);
		address = addr;
		wrdata  = data;
		wrreq   = 1'b1;
		next_cycle();
		wrreq   = 1'b0;
	endtask

	task automatic read_reg(input addr_t addr);
		address = addr;
		rdreq   = 1'b1;
		next_cycle();
		rdreq   = 1'b0;
	endtask

	// Strobe of the access just requested
	task automatic wait_strobe(input logic is_write, input addr_t addr);
		int n;
		n = 0;
		while (!(is_write ? sram_we : sram_oe) && (n < 4)) begin
			next_cycle();
			n++;
		end
		if (!(is_write ? sram_we : sram_oe)) begin
			$display("Timeout waiting for the SRAM strobe of the access at %h", addr);
			$display("Test FAILED");
			$fatal(1, "No SRAM strobe");
		end
	endtask

	// Random read or write in a page, then one idle cycle
	task automatic random_access(input addr_t page);
		data_t off;
		off = rand_byte();
		if (rand_byte() < 8'h80) begin
			read_reg(page | off);
		end else begin
			write_reg(page | off, rand_byte());
		end
		next_cycle();
	endtask

	task automatic view_regions();
		for (int r = 0; r < 4; r++) begin
			address = 16'h4000 + 16'(r) * 16'h2000;
			next_cycle();
		end
	endtask

	// ----------------------------------------------------------------------
	// Stimulus
	// ----------------------------------------------------------------------

	initial begin
		nreset  = 1'b0;
		wrreq   = 1'b0;
		rdreq   = 1'b0;
		address = '0;
		wrdata  = '0;
		repeat (5) @(posedge clk);
		#1;
		nreset = 1'b1;
		view_regions();

		write_reg(16'h5000, rand_byte());
		write_reg(16'h7000, rand_byte());
		write_reg(16'h9000, rand_byte());
		write_reg(16'hB000, rand_byte());
		view_regions();
		// Lock banks 0 and 1, then bit 4 locks all four
		write_reg(16'hBFFE, 8'h03);
		write_reg(16'h5000, rand_byte());
		write_reg(16'h7000, rand_byte());
		view_regions();
		write_reg(16'hBFFF, 8'h10);
		write_reg(16'h9000, rand_byte());
		write_reg(16'hB000, rand_byte());
		view_regions();
		write_reg(16'hBFFE, 8'h00);

		// SCC page, bank 2 locked so page writes keep the key
		write_reg(16'h9000, SCC_BANK_KEY);
		write_reg(16'hBFFE, 8'h04);
		read_reg(16'h9800);
		wait_strobe(1'b0, 16'h9800);
		write_reg(16'h9865, rand_byte());
		wait_strobe(1'b1, 16'h9865);
		read_reg(16'h98A3);
		wait_strobe(1'b0, 16'h98A3);
		write_reg(16'h98B0, rand_byte());
		next_cycle();
		for (int i = 0; i < 16; i++) begin
			write_reg(16'h9880 + 16'(i), rand_byte());
		end
		repeat (40) random_access(16'h9800);

		// SCC-I page, every bank locked by the mode write
		write_reg(16'hB000, 8'h80 | rand_byte());
		write_reg(16'hBFFE, 8'hB0);
		read_reg(16'hB880);
		wait_strobe(1'b0, 16'hB880);
		write_reg(16'hB89F, rand_byte());
		wait_strobe(1'b1, 16'hB89F);
		for (int i = 0; i < 16; i++) begin
			write_reg(16'hB8A0 + 16'(i), rand_byte());
		end
		repeat (40) random_access(16'hB800);
		repeat (20) random_access(16'h9800);
		for (int i = 0; i < 16; i++) begin
			write_reg(16'h9880 + 16'(i), rand_byte());
		end

		repeat (2) next_cycle();
		if (u_dut.u_assert.error_count == 0) begin
			$display("Test OK");
			$finish;
		end else begin
			$display("Test FAILED");
			$fatal(1, "Assertion failures were counted");
		end
	end

endmodule

// ==== scc_regs.f ====
verilog/scc_regs_pkg.sv
verilog/bank_mapper.sv
verilog/wave_access_decode.sv
verilog/tone_regs.sv
verilog/scc_regs_top.sv
verif/scc_regs_assert.sv
verif/scc_regs_tb.sv
